/* logic/io_pkg.sv */
// Widths, register map, baud divisors and the serial control/status word, imported by the RTL.
`default_nettype none

package io_pkg;

	localparam int NUM_PORTS = 3;
	localparam int PIN_W = 7;
	localparam int DATA_W = 8;
	localparam int ADDR_W = 4;

	localparam int OVERSAMPLE = 16; // Sample ticks per bit.
	localparam int SAMPLE_W = $clog2(OVERSAMPLE);
	localparam int FRAME_W = DATA_W + 2; // Start, data and stop.
	localparam int BIT_W = $clog2(FRAME_W);

	// Scaled-down rates, same ratios as the console chip.
	localparam int NUM_BAUD = 4;
	localparam int BAUD_SEL_W = $clog2(NUM_BAUD);
	localparam int unsigned BAUD_DIV [NUM_BAUD] = '{2, 4, 8, 32};
	localparam int PRESCALE_W = $clog2(BAUD_DIV[NUM_BAUD-1]);

	localparam int ADDR_PDATA_BASE = 1;
	localparam int ADDR_PCTRL_BASE = 4;
	localparam int ADDR_SER_BASE = 7; // Tx data, rx data, status per port.
	localparam int SER_STRIDE = 3;

	localparam int TX_PIN = 4;
	localparam int RX_PIN = 5;
	localparam int IRQ_PIN = 6;

	localparam logic [1:0] TX_IDLE = 2'd0;
	localparam logic [1:0] TX_SHIFT = 2'd1;
	localparam logic [1:0] TX_STOP = 2'd2;

	localparam logic [1:0] RX_IDLE = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA = 2'd2;
	localparam logic [1:0] RX_STOP = 2'd3;

	// Written as control bits 7:3, read back with the status bits below them.
	typedef union packed {
		struct packed {
			logic [BAUD_SEL_W-1:0] baud;
			logic rx_en;
			logic tx_en;
			logic rx_ie;
			logic rx_err;
			logic rx_rdy;
			logic tx_full;
		} fields;
		logic [DATA_W-1:0] raw;
	} ser_word_u;

endpackage

`default_nettype wire

/* logic/reg_decode.sv */
// Register bus decoder; turns address and strobes into per-port pulses and muxes read data.
`timescale 1ns/1ps
`default_nettype none

module reg_decode
	(
	input wire MCLK,
	input wire [io_pkg::ADDR_W-1:0] addr_i,
	input wire [io_pkg::DATA_W-1:0] wdata_i,
	input wire wr_i,
	input wire rd_i,
	output logic [io_pkg::NUM_PORTS-1:0] pdata_we_o,
	output logic [io_pkg::NUM_PORTS-1:0] pctrl_we_o,
	output logic [io_pkg::NUM_PORTS-1:0] ser_we_o,
	output logic [io_pkg::NUM_PORTS-1:0] txd_we_o,
	output logic [io_pkg::NUM_PORTS-1:0] rx_read_o,
	input wire [io_pkg::DATA_W-1:0] pdata_i [io_pkg::NUM_PORTS],
	input wire [io_pkg::DATA_W-1:0] pctrl_i [io_pkg::NUM_PORTS],
	input wire io_pkg::ser_word_u serword_i [io_pkg::NUM_PORTS],
	input wire [io_pkg::DATA_W-1:0] txd_i [io_pkg::NUM_PORTS],
	input wire [io_pkg::DATA_W-1:0] rxd_i [io_pkg::NUM_PORTS],
	input wire [io_pkg::PIN_W-1:0] pins_i [io_pkg::NUM_PORTS],
	output logic [io_pkg::DATA_W-1:0] rdata_o
	);

	import io_pkg::*;

	logic [PIN_W-1:0] pins_q [NUM_PORTS];
	logic [DATA_W-1:0] rd_mux;

	always_ff @(posedge MCLK)
	begin
		pins_q <= pins_i; // Pins are sampled once before the read mux.
	end

	always_comb
	begin
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			pdata_we_o[p] = wr_i && addr_i == ADDR_W'(ADDR_PDATA_BASE + p);
			pctrl_we_o[p] = wr_i && addr_i == ADDR_W'(ADDR_PCTRL_BASE + p);
			txd_we_o[p] = wr_i && addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p);
			rx_read_o[p] = rd_i && addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p + 1);
			ser_we_o[p] = wr_i && addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p + 2);
		end
	end

	// Address 0 and unmatched addresses read zero.
	always_comb
	begin
		rd_mux = '0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (addr_i == ADDR_W'(ADDR_PDATA_BASE + p))
				rd_mux = {pdata_i[p][DATA_W-1], pins_q[p]};
			if (addr_i == ADDR_W'(ADDR_PCTRL_BASE + p))
				rd_mux = pctrl_i[p];
			if (addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p))
				rd_mux = txd_i[p];
			if (addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p + 1))
				rd_mux = rxd_i[p];
			if (addr_i == ADDR_W'(ADDR_SER_BASE + SER_STRIDE * p + 2))
				rd_mux = serword_i[p].raw; // Control plus status.
		end
	end

	// During a write cycle the data bus carries the write byte.
	assign rdata_o = wr_i ? wdata_i : rd_mux;

endmodule

`default_nettype wire

/* logic/baud_timer.sv */
// Shared baud prescaler; gives one oversample tick pulse per selectable baud rate.
`timescale 1ns/1ps
`default_nettype none

module baud_timer
	(
	input wire MCLK,
	input wire rst_i,
	output logic [io_pkg::NUM_BAUD-1:0] tick_o
	);

	import io_pkg::*;

	logic [PRESCALE_W-1:0] cnt_q;

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
			cnt_q <= '0;
		else
			cnt_q <= cnt_q + 1'b1; // Wraps at the largest divisor.
	end

	// Divisors are powers of two, so a tick is the low bits all set.
	always_comb
	begin
		for (int k = 0; k < NUM_BAUD; k++)
			tick_o[k] = &(cnt_q | ~PRESCALE_W'(BAUD_DIV[k] - 1));
	end

endmodule

`default_nettype wire

/* logic/port_regs.sv */
// Registers and status flags of one controller port, with pin direction and interrupt logic.
`timescale 1ns/1ps
`default_nettype none

module port_regs
	(
	input wire MCLK,
	input wire rst_i,
	input wire [io_pkg::DATA_W-1:0] wdata_i,
	input wire pdata_we_i,
	input wire pctrl_we_i,
	input wire ser_we_i,
	input wire txd_we_i,
	input wire rx_read_i,
	input wire tx_taken_i,
	input wire rx_done_i,
	input wire stop_bit_i,
	input wire tx_line_i,
	input wire pin6_i,
	output logic [io_pkg::DATA_W-1:0] pdata_o,
	output logic [io_pkg::DATA_W-1:0] pctrl_o,
	output logic [io_pkg::DATA_W-1:0] txd_o,
	output io_pkg::ser_word_u serword_o,
	output logic [io_pkg::PIN_W-1:0] pin_o,
	output logic [io_pkg::PIN_W-1:0] pin_d_o,
	output logic irq_o
	);

	import io_pkg::*;

	ser_word_u wr_word;

	assign wr_word.raw = wdata_i;

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			pdata_o <= '0;
			pctrl_o <= '0;
			txd_o <= '0;
			serword_o.raw <= '0;
		end
		else
		begin
			if (pdata_we_i)
				pdata_o <= wdata_i;
			if (pctrl_we_i)
				pctrl_o <= wdata_i;
			if (txd_we_i)
				txd_o <= wdata_i; // Overwrites a pending byte.
			if (ser_we_i)
			begin
				serword_o.fields.baud <= wr_word.fields.baud;
				serword_o.fields.rx_en <= wr_word.fields.rx_en;
				serword_o.fields.tx_en <= wr_word.fields.tx_en;
				serword_o.fields.rx_ie <= wr_word.fields.rx_ie;
			end
			if (txd_we_i)
				serword_o.fields.tx_full <= 1'b1;
			else if (tx_taken_i)
				serword_o.fields.tx_full <= 1'b0;
			// A completed frame wins over a coinciding read.
			if (rx_done_i)
			begin
				serword_o.fields.rx_rdy <= 1'b1;
				serword_o.fields.rx_err <= ~stop_bit_i;
			end
			else if (rx_read_i)
			begin
				serword_o.fields.rx_rdy <= 1'b0;
				serword_o.fields.rx_err <= 1'b0;
			end
		end
	end

	always_comb
	begin
		pin_d_o = pctrl_o[PIN_W-1:0]; // 1 drives the pin.
		pin_o = pdata_o[PIN_W-1:0];
		if (serword_o.fields.tx_en)
		begin
			pin_d_o[TX_PIN] = 1'b1;
			pin_o[TX_PIN] = tx_line_i;
		end
		if (serword_o.fields.rx_en)
			pin_d_o[RX_PIN] = 1'b0;
	end

	assign irq_o = (~pin6_i & pctrl_o[DATA_W-1])
		| (serword_o.fields.rx_rdy & serword_o.fields.rx_ie);

endmodule

`default_nettype wire

/* logic/serial_sequencer.sv */
// Transmit and receive bit sequencing of one port's UART, paced by the selected oversample tick.
`timescale 1ns/1ps
`default_nettype none

module serial_sequencer
	(
	input wire MCLK,
	input wire rst_i,
	input wire [io_pkg::NUM_BAUD-1:0] tick_i,
	input wire [io_pkg::BAUD_SEL_W-1:0] baud_i,
	input wire tx_en_i,
	input wire rx_en_i,
	input wire tx_full_i,
	input wire rx_pin_i,
	output logic tx_load_o,
	output logic tx_shift_o,
	output logic tx_taken_o,
	output logic rx_shift_o,
	output logic rx_done_o,
	output logic stop_bit_o
	);

	import io_pkg::*;

	logic tick;
	logic tx_tick;
	logic rx_tick;
	logic tx_bit_end;
	logic rx_bit_end;
	logic rx_half;
	logic [1:0] tx_state_q;
	logic [SAMPLE_W-1:0] tx_cnt_q;
	logic [BIT_W-1:0] tx_bit_q;
	logic [1:0] rx_state_q;
	logic [SAMPLE_W-1:0] rx_cnt_q;
	logic [BIT_W-1:0] rx_bit_q;

	assign tick = tick_i[baud_i];
	assign tx_tick = tick & tx_en_i; // A disabled side stalls in place.
	assign rx_tick = tick & rx_en_i;
	assign tx_bit_end = tx_tick && tx_cnt_q == SAMPLE_W'(OVERSAMPLE - 1);
	assign rx_bit_end = rx_tick && rx_cnt_q == SAMPLE_W'(OVERSAMPLE - 1);
	assign rx_half = rx_tick && rx_cnt_q == SAMPLE_W'(OVERSAMPLE / 2 - 1);

	assign tx_load_o = tx_tick && tx_state_q == TX_IDLE && tx_full_i;
	assign tx_taken_o = tx_load_o;
	assign tx_shift_o = tx_bit_end && tx_state_q != TX_IDLE;
	assign rx_shift_o = rx_bit_end && rx_state_q == RX_DATA;
	assign rx_done_o = rx_bit_end && rx_state_q == RX_STOP;
	assign stop_bit_o = rx_done_o & rx_pin_i;

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			tx_state_q <= TX_IDLE;
			tx_cnt_q <= '0;
			tx_bit_q <= '0;
		end
		else
		begin
			if (tx_state_q == TX_IDLE)
				tx_cnt_q <= '0;
			else if (tx_tick)
				tx_cnt_q <= tx_bit_end ? '0 : tx_cnt_q + 1'b1;
			case (tx_state_q)
				TX_IDLE:
					if (tx_load_o)
					begin
						tx_state_q <= TX_SHIFT;
						tx_bit_q <= '0;
					end
				TX_SHIFT:
					if (tx_bit_end)
					begin
						tx_bit_q <= tx_bit_q + 1'b1;
						if (tx_bit_q == BIT_W'(DATA_W)) // Last data bit done, stop bit out.
							tx_state_q <= TX_STOP;
					end
				default:
					if (tx_bit_end)
						tx_state_q <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
		begin
			rx_state_q <= RX_IDLE;
			rx_cnt_q <= '0;
			rx_bit_q <= '0;
		end
		else
		begin
			case (rx_state_q)
				RX_IDLE:
				begin
					rx_cnt_q <= '0;
					if (rx_tick && !rx_pin_i)
						rx_state_q <= RX_START;
				end
				RX_START:
					// Half a bit later the start bit must still be low.
					if (rx_half)
					begin
						rx_cnt_q <= '0;
						rx_bit_q <= '0;
						rx_state_q <= rx_pin_i ? RX_IDLE : RX_DATA;
					end
					else if (rx_tick)
						rx_cnt_q <= rx_cnt_q + 1'b1;
				RX_DATA:
					if (rx_tick)
					begin
						rx_cnt_q <= rx_bit_end ? '0 : rx_cnt_q + 1'b1;
						if (rx_bit_end)
						begin
							rx_bit_q <= rx_bit_q + 1'b1;
							if (rx_bit_q == BIT_W'(DATA_W - 1))
								rx_state_q <= RX_STOP;
						end
					end
				default:
					if (rx_tick)
					begin
						rx_cnt_q <= rx_bit_end ? '0 : rx_cnt_q + 1'b1;
						if (rx_bit_end)
							rx_state_q <= RX_IDLE;
					end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/serial_shifter.sv */
// Transmit frame register, receive shift register and received-data latch of one port.
`timescale 1ns/1ps
`default_nettype none

module serial_shifter
	(
	input wire MCLK,
	input wire rst_i,
	input wire [io_pkg::DATA_W-1:0] txd_i,
	input wire tx_load_i,
	input wire tx_shift_i,
	input wire rx_shift_i,
	input wire rx_done_i,
	input wire rx_pin_i,
	output logic tx_line_o,
	output logic [io_pkg::DATA_W-1:0] rxd_o
	);

	import io_pkg::*;

	logic [FRAME_W-1:0] tx_frame_q;
	logic [DATA_W-1:0] rx_shift_q;

	// Ones shift in behind the frame, so the line idles high.
	always_ff @(posedge MCLK)
	begin
		if (rst_i)
			tx_frame_q <= '1;
		else if (tx_load_i)
			tx_frame_q <= {1'b1, txd_i, 1'b0};
		else if (tx_shift_i)
			tx_frame_q <= {1'b1, tx_frame_q[FRAME_W-1:1]};
	end

	assign tx_line_o = tx_frame_q[0];

	always_ff @(posedge MCLK)
	begin
		if (rx_shift_i)
			rx_shift_q <= {rx_pin_i, rx_shift_q[DATA_W-1:1]}; // LSB arrives first.
	end

	always_ff @(posedge MCLK)
	begin
		if (rst_i)
			rxd_o <= '0;
		else if (rx_done_i)
			rxd_o <= rx_shift_q;
	end

endmodule

`default_nettype wire

/* logic/io_ctrl_top.sv */
// Top of the three-port I/O controller; connects the register bus, the prescaler and the ports.
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_top
	(
	input wire MCLK,
	input wire rst_i,
	input wire [io_pkg::ADDR_W-1:0] addr_i,
	input wire [io_pkg::DATA_W-1:0] wdata_i,
	input wire wr_i,
	input wire rd_i,
	output logic [io_pkg::DATA_W-1:0] rdata_o,
	input wire [io_pkg::PIN_W-1:0] port_a_i,
	input wire [io_pkg::PIN_W-1:0] port_b_i,
	input wire [io_pkg::PIN_W-1:0] port_c_i,
	output logic [io_pkg::PIN_W-1:0] port_a_o,
	output logic [io_pkg::PIN_W-1:0] port_b_o,
	output logic [io_pkg::PIN_W-1:0] port_c_o,
	output logic [io_pkg::PIN_W-1:0] port_a_d,
	output logic [io_pkg::PIN_W-1:0] port_b_d,
	output logic [io_pkg::PIN_W-1:0] port_c_d,
	output logic int_n_o
	);

	import io_pkg::*;

	logic [PIN_W-1:0] pin_in [NUM_PORTS];
	logic [PIN_W-1:0] pin_out [NUM_PORTS];
	logic [PIN_W-1:0] pin_dir [NUM_PORTS];
	logic [NUM_PORTS-1:0] pdata_we;
	logic [NUM_PORTS-1:0] pctrl_we;
	logic [NUM_PORTS-1:0] ser_we;
	logic [NUM_PORTS-1:0] txd_we;
	logic [NUM_PORTS-1:0] rx_read;
	logic [DATA_W-1:0] pdata [NUM_PORTS];
	logic [DATA_W-1:0] pctrl [NUM_PORTS];
	logic [DATA_W-1:0] txd [NUM_PORTS];
	logic [DATA_W-1:0] rxd [NUM_PORTS];
	ser_word_u serword [NUM_PORTS];
	logic [NUM_BAUD-1:0] tick;
	logic [NUM_PORTS-1:0] tx_load;
	logic [NUM_PORTS-1:0] tx_shift;
	logic [NUM_PORTS-1:0] tx_taken;
	logic [NUM_PORTS-1:0] rx_shift;
	logic [NUM_PORTS-1:0] rx_done;
	logic [NUM_PORTS-1:0] stop_bit;
	logic [NUM_PORTS-1:0] tx_line;
	logic [NUM_PORTS-1:0] irq;

	assign pin_in[0] = port_a_i;
	assign pin_in[1] = port_b_i;
	assign pin_in[2] = port_c_i;
	assign port_a_o = pin_out[0];
	assign port_b_o = pin_out[1];
	assign port_c_o = pin_out[2];
	assign port_a_d = pin_dir[0];
	assign port_b_d = pin_dir[1];
	assign port_c_d = pin_dir[2];

	assign int_n_o = ~|irq; // Any port pulls the line low.

	reg_decode u_decode (.MCLK(MCLK), .addr_i(addr_i), .wdata_i(wdata_i), .wr_i(wr_i),
		.rd_i(rd_i), .pdata_we_o(pdata_we), .pctrl_we_o(pctrl_we), .ser_we_o(ser_we),
		.txd_we_o(txd_we), .rx_read_o(rx_read), .pdata_i(pdata), .pctrl_i(pctrl),
		.serword_i(serword), .txd_i(txd), .rxd_i(rxd), .pins_i(pin_in), .rdata_o(rdata_o));

	baud_timer u_timer (.MCLK(MCLK), .rst_i(rst_i), .tick_o(tick));

	for (genvar g = 0; g < NUM_PORTS; g++)
	begin : g_port
		port_regs u_regs (.MCLK(MCLK), .rst_i(rst_i), .wdata_i(wdata_i),
			.pdata_we_i(pdata_we[g]), .pctrl_we_i(pctrl_we[g]), .ser_we_i(ser_we[g]),
			.txd_we_i(txd_we[g]), .rx_read_i(rx_read[g]), .tx_taken_i(tx_taken[g]),
			.rx_done_i(rx_done[g]), .stop_bit_i(stop_bit[g]), .tx_line_i(tx_line[g]),
			.pin6_i(pin_in[g][IRQ_PIN]), .pdata_o(pdata[g]), .pctrl_o(pctrl[g]),
			.txd_o(txd[g]), .serword_o(serword[g]), .pin_o(pin_out[g]),
			.pin_d_o(pin_dir[g]), .irq_o(irq[g]));

		serial_sequencer u_seq (.MCLK(MCLK), .rst_i(rst_i), .tick_i(tick),
			.baud_i(serword[g].fields.baud), .tx_en_i(serword[g].fields.tx_en),
			.rx_en_i(serword[g].fields.rx_en), .tx_full_i(serword[g].fields.tx_full),
			.rx_pin_i(pin_in[g][RX_PIN]), .tx_load_o(tx_load[g]), .tx_shift_o(tx_shift[g]),
			.tx_taken_o(tx_taken[g]), .rx_shift_o(rx_shift[g]), .rx_done_o(rx_done[g]),
			.stop_bit_o(stop_bit[g]));

		serial_shifter u_shift (.MCLK(MCLK), .rst_i(rst_i), .txd_i(txd[g]),
			.tx_load_i(tx_load[g]), .tx_shift_i(tx_shift[g]), .rx_shift_i(rx_shift[g]),
			.rx_done_i(rx_done[g]), .rx_pin_i(pin_in[g][RX_PIN]), .tx_line_o(tx_line[g]),
			.rxd_o(rxd[g]));
	end

endmodule

`default_nettype wire

/* test/io_ctrl_checker.sv */
// Concurrent assertions on port A's strobes and status bits, bound into io_ctrl_top.
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_checker
	(
	input wire MCLK,
	input wire rst_i,
	input wire [io_pkg::NUM_BAUD-1:0] tick_i,
	input wire rx_read_i,
	input wire rx_done_i,
	input wire rx_rdy_i,
	input wire rx_en_i,
	input wire tx_idle_i,
	input wire tx_line_i
	);

	import io_pkg::*;

	for (genvar k = 0; k < NUM_BAUD; k++)
	begin : g_tick
		tick_width: assert property (@(posedge MCLK) disable iff (rst_i)
			tick_i[k] |=> !tick_i[k])
			else $error("Tick %0d wider than one cycle", k);
	end

	ready_clear: assert property (@(posedge MCLK) disable iff (rst_i)
		rx_read_i && !rx_done_i |=> !rx_rdy_i)
		else $error("Ready not cleared by rx read");

	ready_disabled: assert property (@(posedge MCLK) disable iff (rst_i)
		!rx_en_i && !rx_rdy_i |=> !rx_rdy_i)
		else $error("Ready rose with rx disabled");

	tx_idle_high: assert property (@(posedge MCLK) disable iff (rst_i)
		tx_idle_i |-> tx_line_i)
		else $error("Tx line low while idle");

endmodule

bind io_ctrl_top io_ctrl_checker u_check (.MCLK(MCLK), .rst_i(rst_i), .tick_i(tick),
	.rx_read_i(rx_read[0]), .rx_done_i(rx_done[0]), .rx_rdy_i(serword[0].fields.rx_rdy),
	.rx_en_i(serword[0].fields.rx_en),
	.tx_idle_i(g_port[0].u_seq.tx_state_q == io_pkg::TX_IDLE), .tx_line_i(tx_line[0]));

`default_nettype wire

/* test/io_ctrl_tb.sv */
// Testbench for io_ctrl_top; drives the bus and pins, checks registers, UART and interrupts.
`timescale 1ns/1ps
`default_nettype none

module io_ctrl_tb;

	import io_pkg::*;

	localparam int SEED = 32'h0ef6db8e;
	localparam int BAUD_SEL = 0; // Fastest rate keeps the run short.
	localparam int BIT_CYC = OVERSAMPLE * BAUD_DIV[BAUD_SEL];
	localparam int FRAMES = 3;
	localparam int TIMEOUT_CYC = FRAMES * FRAME_W * BIT_CYC * 2 + 2000;
	localparam logic [7:0] SER_ON = 8'h38; // Baud 0, rx, tx and rx interrupt enabled.

	logic MCLK = 1'b0;
	logic rst_i;
	logic [ADDR_W-1:0] addr_i;
	logic [DATA_W-1:0] wdata_i;
	logic wr_i;
	logic rd_i;
	logic [DATA_W-1:0] rdata_o;
	logic [PIN_W-1:0] port_a_i;
	logic [PIN_W-1:0] port_b_i;
	logic [PIN_W-1:0] port_c_i;
	logic [PIN_W-1:0] port_a_o;
	logic [PIN_W-1:0] port_b_o;
	logic [PIN_W-1:0] port_c_o;
	logic [PIN_W-1:0] port_a_d;
	logic [PIN_W-1:0] port_b_d;
	logic [PIN_W-1:0] port_c_d;
	logic int_n_o;

	string name_q[$];
	logic [7:0] exp_q[$];
	logic [7:0] act_q[$];
	event check_ev;
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	string cmp_name;
	logic [7:0] cmp_exp;
	logic [7:0] cmp_act;
	logic [7:0] rd_val;
	logic [7:0] d;
	logic [7:0] c;
	logic [7:0] b;
	ser_word_u stat;
	logic [PIN_W-1:0] pins;
	logic line;

	io_ctrl_top UUT (.MCLK(MCLK), .rst_i(rst_i), .addr_i(addr_i), .wdata_i(wdata_i),
		.wr_i(wr_i), .rd_i(rd_i), .rdata_o(rdata_o), .port_a_i(port_a_i),
		.port_b_i(port_b_i), .port_c_i(port_c_i), .port_a_o(port_a_o), .port_b_o(port_b_o),
		.port_c_o(port_c_o), .port_a_d(port_a_d), .port_b_d(port_b_d),
		.port_c_d(port_c_d), .int_n_o(int_n_o));

	always #50 MCLK = ~MCLK;

	always @(posedge MCLK)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// Expected line level of bit idx in a frame: start, data LSB first, stop.
	function automatic logic frame_bit(input logic [7:0] val, input int idx);
		if (idx == 0)
			return 1'b0;
		else if (idx <= DATA_W)
			return val[idx-1];
		return 1'b1;
	endfunction

	function automatic logic [PIN_W-1:0] pin_out(input int p);
		case (p)
			0: return port_a_o;
			1: return port_b_o;
			default: return port_c_o;
		endcase
	endfunction

	function automatic logic [PIN_W-1:0] pin_dir(input int p);
		case (p)
			0: return port_a_d;
			1: return port_b_d;
			default: return port_c_d;
		endcase
	endfunction

	task automatic set_pins(input int p, input logic [PIN_W-1:0] v);
		case (p)
			0: port_a_i <= v;
			1: port_b_i <= v;
			default: port_c_i <= v;
		endcase
	endtask

	task automatic expect_eq(input string name, input logic [7:0] exp, input logic [7:0] act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
		-> check_ev;
	endtask

	task automatic write_reg(input int a, input logic [7:0] val);
		@(posedge MCLK);
		addr_i <= ADDR_W'(a);
		wdata_i <= val;
		wr_i <= 1'b1;
		@(posedge MCLK);
		wr_i <= 1'b0;
	endtask

	// Data is taken at the falling edge, while addr_i is steady.
	task automatic read_reg(input int a, input logic strobe, output logic [7:0] val);
		@(posedge MCLK);
		addr_i <= ADDR_W'(a);
		rd_i <= strobe;
		@(negedge MCLK);
		val = rdata_o;
		@(posedge MCLK);
		rd_i <= 1'b0;
	endtask

	task automatic wait_ready(output ser_word_u val);
		val.raw = 8'h00;
		while (!val.fields.rx_rdy)
			read_reg(ADDR_SER_BASE + 2, 1'b0, val.raw);
	endtask

	// The stop bit is held a little past its centre, then the line idles high.
	task automatic drive_frame(input logic [7:0] val, input logic stop);
		for (int i = 0; i < FRAME_W - 1; i++)
		begin
			@(posedge MCLK);
			port_a_i[RX_PIN] <= frame_bit(val, i);
			repeat (BIT_CYC - 1) @(posedge MCLK);
		end
		@(posedge MCLK);
		port_a_i[RX_PIN] <= stop;
		repeat (BIT_CYC / 2 + 4) @(posedge MCLK);
		port_a_i[RX_PIN] <= 1'b1;
		repeat (BIT_CYC / 2) @(posedge MCLK);
	endtask

	// Comparing process.
	initial
	begin
		forever
		begin
			@(check_ev);
			while (name_q.size() != 0)
			begin
				cmp_name = name_q.pop_front();
				cmp_exp = exp_q.pop_front();
				cmp_act = act_q.pop_front();
				checks++;
				assert (cmp_exp === cmp_act)
				else
				begin
					errors++;
					$display("** Error %s: expected %h, actual %h", cmp_name, cmp_exp, cmp_act);
				end
			end
		end
	end

	initial
	begin
		void'($urandom(SEED));
		rst_i = 1'b1;
		addr_i = '0;
		wdata_i = '0;
		wr_i = 1'b0;
		rd_i = 1'b0;
		port_a_i = '0;
		port_b_i = '0;
		port_c_i = '0;
		repeat (8) @(posedge MCLK);
		rst_i <= 1'b0;

		// Reset values.
		for (int a = 0; a < 16; a++)
		begin
			read_reg(a, 1'b0, rd_val);
			expect_eq($sformatf("reset read %0d", a), 8'h00, rd_val);
		end
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			expect_eq("reset pin out", 8'h00, 8'(pin_out(p)));
			expect_eq("reset pin dir", 8'h00, 8'(pin_dir(p)));
		end
		expect_eq("reset int_n", 8'h01, 8'(int_n_o));

		// Parallel data and control registers.
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			d = 8'($urandom);
			c = 8'($urandom);
			pins = 7'($urandom);
			set_pins(p, pins);
			write_reg(ADDR_PDATA_BASE + p, d);
			write_reg(ADDR_PCTRL_BASE + p, c);
			read_reg(ADDR_PDATA_BASE + p, 1'b0, rd_val);
			expect_eq("data readback", {d[7], pins}, rd_val);
			read_reg(ADDR_PCTRL_BASE + p, 1'b0, rd_val);
			expect_eq("control readback", c, rd_val);
			expect_eq("pin out", 8'(d[6:0]), 8'(pin_out(p)));
			expect_eq("pin dir", 8'(c[6:0]), 8'(pin_dir(p)));
		end
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			write_reg(ADDR_PCTRL_BASE + p, 8'h00);
			write_reg(ADDR_PDATA_BASE + p, 8'h00);
			set_pins(p, 7'h7f);
		end
		@(negedge MCLK);
		expect_eq("idle int_n", 8'h01, 8'(int_n_o));

		// Transmit on port A.
		write_reg(ADDR_SER_BASE + 2, SER_ON);
		b = 8'($urandom);
		write_reg(ADDR_SER_BASE, b);
		@(negedge MCLK);
		while (port_a_o[TX_PIN] !== 1'b0)
			@(negedge MCLK);
		expect_eq("tx pin dir", 8'h01, 8'(port_a_d[TX_PIN]));
		repeat (BIT_CYC / 2) @(negedge MCLK);
		for (int i = 0; i < FRAME_W; i++)
		begin
			line = port_a_o[TX_PIN];
			expect_eq($sformatf("tx bit %0d", i), 8'(frame_bit(b, i)), 8'(line));
			if (i < FRAME_W - 1)
				repeat (BIT_CYC) @(negedge MCLK);
		end
		read_reg(ADDR_SER_BASE + 2, 1'b0, stat.raw);
		expect_eq("tx full cleared", 8'h00, 8'(stat.fields.tx_full));

		// All pins asked as outputs; rx enable keeps pin 5 an input.
		write_reg(ADDR_PCTRL_BASE, 8'h7f);
		@(negedge MCLK);
		expect_eq("rx pin dir", 8'h5f, 8'(port_a_d));
		write_reg(ADDR_PCTRL_BASE, 8'h00);

		// Receive on port A.
		b = 8'($urandom);
		drive_frame(b, 1'b1);
		wait_ready(stat);
		expect_eq("rx error", 8'h00, 8'(stat.fields.rx_err));
		expect_eq("rx int_n low", 8'h00, 8'(int_n_o));
		read_reg(ADDR_SER_BASE + 1, 1'b1, rd_val);
		expect_eq("rx data", b, rd_val);
		read_reg(ADDR_SER_BASE + 2, 1'b0, stat.raw);
		expect_eq("rx ready cleared", 8'h00, 8'({stat.fields.rx_err, stat.fields.rx_rdy}));
		expect_eq("rx int_n high", 8'h01, 8'(int_n_o));

		// Framing error.
		b = 8'($urandom);
		drive_frame(b, 1'b0);
		wait_ready(stat);
		expect_eq("frame error status", 8'h01, 8'(stat.fields.rx_err));
		read_reg(ADDR_SER_BASE + 1, 1'b1, rd_val);
		expect_eq("frame error data", b, rd_val);

		// Pin-6 interrupt on port B.
		write_reg(ADDR_PCTRL_BASE + 1, 8'h80);
		@(posedge MCLK);
		port_b_i[IRQ_PIN] <= 1'b0;
		@(negedge MCLK);
		expect_eq("pin6 int low", 8'h00, 8'(int_n_o));
		@(posedge MCLK);
		port_b_i[IRQ_PIN] <= 1'b1;
		@(negedge MCLK);
		expect_eq("pin6 rise", 8'h01, 8'(int_n_o));
		@(posedge MCLK);
		port_b_i[IRQ_PIN] <= 1'b0;
		write_reg(ADDR_PCTRL_BASE + 1, 8'h00);
		@(negedge MCLK);
		expect_eq("pin6 masked", 8'h01, 8'(int_n_o));

		#1;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* io_ctrl.f */
logic/io_pkg.sv
logic/reg_decode.sv
logic/baud_timer.sv
logic/port_regs.sv
logic/serial_sequencer.sv
logic/serial_shifter.sv
logic/io_ctrl_top.sv
test/io_ctrl_checker.sv
test/io_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the io_ctrl testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module io_ctrl_tb -f io_ctrl.f -o sim_io_ctrl \
	> build.log 2>&1 \
	&& ./obj_dir/sim_io_ctrl > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }
cat sim.log
grep -q "TESTS PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
